// ==== logic/cpu_defines.svh ====
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// datapath widths
`define XLEN        32
`define REG_ADDR_W  5

// memory byte-address widths
`define IMEM_ADDR_W 12
`define DMEM_ADDR_W 12

// major opcodes of the supported subset
`define OP_LUI      7'b0110111
`define OP_OP       7'b0110011
`define OP_IMM      7'b0010011
`define OP_LOAD     7'b0000011
`define OP_STORE    7'b0100011
`define OP_BRANCH   7'b1100011
`define OP_JAL      7'b1101111
`define OP_JALR     7'b1100111

`endif

// ==== logic/cpu_pkg.sv ====
`default_nettype none

`include "cpu_defines.svh"

package cpu_pkg;

    typedef logic [`XLEN-1:0]        word_t;
    typedef logic [31:0]             inst_t;
    typedef logic [`REG_ADDR_W-1:0]  reg_addr_t;
    typedef logic [`IMEM_ADDR_W-1:0] imem_addr_t;
    typedef logic [`DMEM_ADDR_W-1:0] dmem_addr_t;
    typedef logic [3:0]              byte_en_t;
    // low two bits give access size, bit 2 marks unsigned loads
    typedef logic [2:0]              funct3_t;

    typedef enum logic [2:0] {
        FETCH,
        FETCH_WAIT,
        DECODE,
        EXECUTE,
        EXECUTE_WAIT,
        WRITE,
        HALT
    } seq_state_t;

    typedef enum logic [3:0] {
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND, PASS_B
    } alu_op_t;

    typedef struct packed {
        logic      is_alu;
        logic      is_load;
        logic      is_store;
        logic      is_branch;
        logic      is_jal;
        logic      is_jalr;
        logic      illegal;
        alu_op_t   alu_op;
        logic      use_imm;
        funct3_t   funct3;
        reg_addr_t rd;
        logic      rd_write;
        word_t     imm;
    } ctrl_t;

endpackage

`default_nettype wire

// ==== logic/mem_req_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface mem_req_if import cpu_pkg::*; ();

    // request side, one pulse per access
    logic       req;
    logic       store;
    dmem_addr_t addr;
    word_t      wdata;
    funct3_t    size;

    // response side
    logic       done;
    word_t      rdata;

    modport master (output req, store, addr, wdata, size, input done, rdata);
    modport slave  (input req, store, addr, wdata, size, output done, rdata);

endinterface

`default_nettype wire

// ==== logic/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defines.svh"

module reg_file import cpu_pkg::*; (
    input  wire       clk,
    input  wire       rstn,
    input  reg_addr_t rs1,
    input  reg_addr_t rs2,
    output word_t     rs1_data,
    output word_t     rs2_data,
    input  wire       wr_en,
    input  reg_addr_t rd,
    input  word_t     rd_data
);

    word_t regs [0:(1 << `REG_ADDR_W)-1];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < (1 << `REG_ADDR_W); i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && rd != '0) begin
            regs[rd] <= rd_data;
        end
    end

    // x0 is never written, so it reads zero
    assign rs1_data = regs[rs1];
    assign rs2_data = regs[rs2];

    a_wr_known: assert property (@(posedge clk) disable iff (!rstn)
        wr_en |-> !$isunknown(rd_data));

endmodule

`default_nettype wire

// ==== logic/inst_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defines.svh"

module inst_decode import cpu_pkg::*; (
    input  inst_t     inst,
    output ctrl_t     ctrl,
    output reg_addr_t rs1,
    output reg_addr_t rs2
);

    logic [6:0] opcode;
    funct3_t    funct3;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;

    // alt selects SUB and SRA
    function automatic alu_op_t alu_from_funct3(input funct3_t f3, input logic alt);
        case (f3)
            3'b000:  return alt ? SUB : ADD;
            3'b001:  return SLL;
            3'b010:  return SLT;
            3'b011:  return SLTU;
            3'b100:  return XOR;
            3'b101:  return alt ? SRA : SRL;
            3'b110:  return OR;
            default: return AND;
        endcase
    endfunction

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];

    // immediate formats
    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        ctrl        = '0;
        ctrl.alu_op = ADD;
        ctrl.funct3 = funct3;
        ctrl.rd     = inst[11:7];
        case (opcode)
            `OP_LUI: begin
                ctrl.is_alu   = 1'b1;
                ctrl.alu_op   = PASS_B;
                ctrl.use_imm  = 1'b1;
                ctrl.imm      = imm_u;
                ctrl.rd_write = 1'b1;
            end
            `OP_OP: begin
                ctrl.is_alu   = 1'b1;
                ctrl.alu_op   = alu_from_funct3(funct3, inst[30]);
                ctrl.rd_write = 1'b1;
            end
            `OP_IMM: begin
                // only srai uses bit 30, addi has no subtract form
                ctrl.is_alu   = 1'b1;
                ctrl.alu_op   = alu_from_funct3(funct3, (funct3 == 3'b101) && inst[30]);
                ctrl.use_imm  = 1'b1;
                ctrl.imm      = imm_i;
                ctrl.rd_write = 1'b1;
            end
            `OP_LOAD: begin
                ctrl.is_load  = 1'b1;
                ctrl.use_imm  = 1'b1;
                ctrl.imm      = imm_i;
                ctrl.rd_write = 1'b1;
            end
            `OP_STORE: begin
                ctrl.is_store = 1'b1;
                ctrl.use_imm  = 1'b1;
                ctrl.imm      = imm_s;
            end
            `OP_BRANCH: begin
                ctrl.is_branch = 1'b1;
                ctrl.imm       = imm_b;
            end
            `OP_JAL: begin
                ctrl.is_jal   = 1'b1;
                ctrl.imm      = imm_j;
                ctrl.rd_write = 1'b1;
            end
            `OP_JALR: begin
                ctrl.is_jalr  = 1'b1;
                ctrl.use_imm  = 1'b1;
                ctrl.imm      = imm_i;
                ctrl.rd_write = 1'b1;
            end
            default: begin
                ctrl.illegal = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu import cpu_pkg::*; (
    input  alu_op_t op,
    input  word_t   a,
    input  word_t   b,
    input  funct3_t cond,
    output word_t   result,
    output logic    taken
);

    logic [4:0] shamt;
    logic       lt_s;
    logic       lt_u;

    assign shamt = b[4:0];
    assign lt_s  = $signed(a) < $signed(b);
    assign lt_u  = a < b;

    always_comb begin
        case (op)
            ADD:     result = a + b;
            SUB:     result = a - b;
            SLL:     result = a << shamt;
            SLT:     result = word_t'(lt_s);
            SLTU:    result = word_t'(lt_u);
            XOR:     result = a ^ b;
            SRL:     result = a >> shamt;
            SRA:     result = word_t'($signed(a) >>> shamt);
            OR:      result = a | b;
            AND:     result = a & b;
            PASS_B:  result = b;
            default: result = '0;
        endcase
    end

    // branch condition from funct3
    always_comb begin
        case (cond)
            3'b000:  taken = (a == b);
            3'b001:  taken = (a != b);
            3'b100:  taken = lt_s;
            3'b101:  taken = !lt_s;
            3'b110:  taken = lt_u;
            3'b111:  taken = !lt_u;
            default: taken = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/data_mem_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module data_mem_port import cpu_pkg::*; (
    input  wire         clk,
    input  wire         rstn,
    mem_req_if.slave    bus,
    output dmem_addr_t  dmem_addr,
    output word_t       dmem_wdata,
    output byte_en_t    dmem_be,
    output logic        dmem_re,
    input  word_t       dmem_rdata
);

    logic       active_q;
    logic       done_q;
    logic       store_q;
    dmem_addr_t addr_q;
    word_t      wdata_q;
    funct3_t    size_q;
    logic [4:0] lane_shift;
    byte_en_t   be;
    word_t      lane;

    // access cycle follows req, response cycle follows that
    always_ff @(posedge clk) begin
        if (!rstn) begin
            active_q <= 1'b0;
            done_q   <= 1'b0;
        end else begin
            active_q <= bus.req;
            done_q   <= active_q;
        end
    end

    always_ff @(posedge clk) begin
        if (bus.req) begin
            store_q <= bus.store;
            addr_q  <= bus.addr;
            wdata_q <= bus.wdata;
            size_q  <= bus.size;
        end
    end

    assign lane_shift = {addr_q[1:0], 3'b000};

    always_comb begin
        case (size_q[1:0])
            2'b00:   be = byte_en_t'(4'b0001 << addr_q[1:0]);
            2'b01:   be = byte_en_t'(4'b0011 << addr_q[1:0]);
            default: be = 4'b1111;
        endcase
    end

    assign dmem_addr  = addr_q;
    assign dmem_wdata = wdata_q << lane_shift;
    assign dmem_be    = (active_q && store_q) ? be : '0;
    assign dmem_re    = active_q && !store_q;

    // pick the addressed lane, then extend
    assign lane = dmem_rdata >> lane_shift;

    always_comb begin
        case (size_q)
            3'b000:  bus.rdata = {{24{lane[7]}}, lane[7:0]};
            3'b001:  bus.rdata = {{16{lane[15]}}, lane[15:0]};
            3'b100:  bus.rdata = {24'b0, lane[7:0]};
            3'b101:  bus.rdata = {16'b0, lane[15:0]};
            default: bus.rdata = lane;
        endcase
    end

    assign bus.done = done_q;

    a_aligned: assert property (@(posedge clk) disable iff (!rstn)
        bus.req |-> (bus.size[1:0] == 2'b00)
                 || (bus.size[1:0] == 2'b01 && !bus.addr[0])
                 || (bus.addr[1:0] == 2'b00));

endmodule

`default_nettype wire

// ==== logic/cpu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defines.svh"

module cpu_top import cpu_pkg::*; (
    input  wire        clk,
    input  wire        rstn,
    output imem_addr_t imem_addr,
    input  inst_t      imem_data,
    output dmem_addr_t dmem_addr,
    output word_t      dmem_wdata,
    output byte_en_t   dmem_be,
    output logic       dmem_re,
    input  word_t      dmem_rdata,
    output logic       halted
);

    seq_state_t state;
    imem_addr_t pc;
    imem_addr_t next_pc;
    imem_addr_t pc_plus4;
    imem_addr_t pc_target;
    inst_t      inst_q;
    ctrl_t      ctrl_d;
    ctrl_t      ctrl_q;
    reg_addr_t  rs1_addr;
    reg_addr_t  rs2_addr;
    word_t      rs1_data;
    word_t      rs2_data;
    word_t      rs1_q;
    word_t      rs2_q;
    word_t      alu_b;
    word_t      alu_result;
    logic       taken;
    word_t      link;
    word_t      wb_data;
    logic       is_mem;

    mem_req_if mem_bus ();

    reg_file reg_file_inst (
        .clk      (clk),
        .rstn     (rstn),
        .rs1      (rs1_addr),
        .rs2      (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wr_en    (state == WRITE && ctrl_q.rd_write),
        .rd       (ctrl_q.rd),
        .rd_data  (wb_data)
    );

    inst_decode inst_decode_inst (
        .inst (inst_q),
        .ctrl (ctrl_d),
        .rs1  (rs1_addr),
        .rs2  (rs2_addr)
    );

    assign alu_b = ctrl_q.use_imm ? ctrl_q.imm : rs2_q;

    alu alu_inst (
        .op     (ctrl_q.alu_op),
        .a      (rs1_q),
        .b      (alu_b),
        .cond   (ctrl_q.funct3),
        .result (alu_result),
        .taken  (taken)
    );

    data_mem_port data_mem_port_inst (
        .clk        (clk),
        .rstn       (rstn),
        .bus        (mem_bus.slave),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_be    (dmem_be),
        .dmem_re    (dmem_re),
        .dmem_rdata (dmem_rdata)
    );

    assign imem_addr = pc;
    assign halted    = (state == HALT);

    assign pc_plus4  = pc + imem_addr_t'(4);
    assign pc_target = pc + ctrl_q.imm[`IMEM_ADDR_W-1:0];
    assign link      = word_t'(pc) + 32'd4;
    assign is_mem    = ctrl_q.is_load || ctrl_q.is_store;

    // memory request, address from rs1 + imm
    assign mem_bus.req   = (state == EXECUTE) && is_mem;
    assign mem_bus.store = ctrl_q.is_store;
    assign mem_bus.addr  = alu_result[`DMEM_ADDR_W-1:0];
    assign mem_bus.wdata = rs2_q;
    assign mem_bus.size  = ctrl_q.funct3;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= FETCH;
            pc    <= '0;
        end else begin
            case (state)
                FETCH:      state <= FETCH_WAIT;
                FETCH_WAIT: state <= DECODE;
                DECODE:     state <= EXECUTE;
                EXECUTE: begin
                    if (ctrl_q.illegal) begin
                        state <= HALT;
                    end else if (is_mem) begin
                        state <= EXECUTE_WAIT;
                    end else begin
                        state <= WRITE;
                    end
                end
                EXECUTE_WAIT: begin
                    if (mem_bus.done) begin
                        state <= WRITE;
                    end
                end
                WRITE: begin
                    pc    <= {next_pc[`IMEM_ADDR_W-1:2], 2'b00};
                    state <= FETCH;
                end
                HALT:    state <= HALT;
                default: state <= HALT;
            endcase
        end
    end

    // datapath registers, sequenced by state
    always_ff @(posedge clk) begin
        case (state)
            FETCH_WAIT: inst_q <= imem_data;
            DECODE: begin
                ctrl_q <= ctrl_d;
                rs1_q  <= rs1_data;
                rs2_q  <= rs2_data;
            end
            EXECUTE: begin
                if (ctrl_q.is_jal) begin
                    next_pc <= pc_target;
                    wb_data <= link;
                end else if (ctrl_q.is_jalr) begin
                    next_pc <= alu_result[`IMEM_ADDR_W-1:0];
                    wb_data <= link;
                end else if (ctrl_q.is_branch) begin
                    next_pc <= taken ? pc_target : pc_plus4;
                end else begin
                    next_pc <= pc_plus4;
                    wb_data <= alu_result;
                end
            end
            EXECUTE_WAIT: begin
                // load value is only valid during done
                if (mem_bus.done) begin
                    wb_data <= mem_bus.rdata;
                end
            end
            default: begin
            end
        endcase
    end

    // done comes back exactly two cycles later, while the sequencer waits for it
    a_done_after_req: assert property (@(posedge clk) disable iff (!rstn)
        mem_bus.req |-> !mem_bus.done ##1 !mem_bus.done
                        ##1 (mem_bus.done && state == EXECUTE_WAIT));

endmodule

`default_nettype wire

// ==== bench/tb_cpu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defines.svh"

module tb_cpu import cpu_pkg::*;;

    localparam int CLK_PERIOD      = 8;
    localparam int RESET_CYCLES    = 2;
    localparam int PROG_LEN        = 200;
    localparam int IMEM_WORDS      = 1 << (`IMEM_ADDR_W - 2);
    localparam int DMEM_WORDS      = 1 << (`DMEM_ADDR_W - 2);
    localparam int DATA_BASE       = 'h400;
    localparam int JALR_BASE       = 'h100;
    localparam int WATCHDOG_CYCLES = PROG_LEN * 8 + 100;
    localparam logic [31:0] SEED   = 32'hf9c7_bce2;

    logic       clk = 1'b0;
    logic       rstn;
    imem_addr_t imem_addr;
    inst_t      imem_data;
    dmem_addr_t dmem_addr;
    word_t      dmem_wdata;
    byte_en_t   dmem_be;
    logic       dmem_re;
    word_t      dmem_rdata;
    logic       halted;

    inst_t       irom [0:IMEM_WORDS-1];
    word_t       dram [0:DMEM_WORDS-1];
    word_t       model_dram [0:DMEM_WORDS-1];
    logic [31:0] rand_state;
    dmem_addr_t  exp_addr_q [$];
    byte_en_t    exp_be_q [$];
    word_t       exp_data_q [$];
    int          model_inst;
    int          model_mem;
    word_t       model_final_pc;
    int          store_count = 0;
    int          cycle = 0;
    int          halt_cycle;
    int          exp_halt_cycle;

    cpu_top cpu_top_inst (
        .clk        (clk),
        .rstn       (rstn),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_be    (dmem_be),
        .dmem_re    (dmem_re),
        .dmem_rdata (dmem_rdata),
        .halted     (halted)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    task automatic report_failure();
        $display("Result: FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            report_failure();
        end
    endtask

    task automatic check_be(input string name, input byte_en_t got, input byte_en_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
            report_failure();
        end
    endtask

    task automatic check_addr(input string name, input dmem_addr_t got, input dmem_addr_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            report_failure();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
            report_failure();
        end
    endtask

    // lcg with the usual 32-bit constants
    function automatic logic [31:0] lcg_next();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    // high half only, low lcg bits repeat quickly
    function automatic int random_below(input int n);
        return int'((lcg_next() >> 16) % n);
    endfunction

    function automatic reg_addr_t src_reg();
        return reg_addr_t'(random_below(16));
    endfunction

    // x1 and x2 stay reserved as data base and jump base
    function automatic reg_addr_t dest_reg();
        return reg_addr_t'(3 + random_below(13));
    endfunction

    function automatic logic [11:0] aligned_offset(input funct3_t f3);
        case (f3[1:0])
            2'b00:   return 12'(random_below(256));
            2'b01:   return 12'(random_below(128) * 2);
            default: return 12'(random_below(64) * 4);
        endcase
    endfunction

    function automatic word_t byte_lanes(input byte_en_t be);
        return {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    endfunction

    // instruction formats
    function automatic inst_t r_format(input logic [6:0] f7, input reg_addr_t rs2,
                                       input reg_addr_t rs1, input funct3_t f3,
                                       input reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, `OP_OP};
    endfunction

    function automatic inst_t i_format(input logic [11:0] imm, input reg_addr_t rs1,
                                       input funct3_t f3, input reg_addr_t rd,
                                       input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic inst_t s_format(input logic [11:0] imm, input reg_addr_t rs2,
                                       input reg_addr_t rs1, input funct3_t f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], `OP_STORE};
    endfunction

    function automatic inst_t b_format(input logic [12:0] imm, input reg_addr_t rs2,
                                       input reg_addr_t rs1, input funct3_t f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `OP_BRANCH};
    endfunction

    function automatic inst_t j_format(input logic [20:0] imm, input reg_addr_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `OP_JAL};
    endfunction

    task automatic build_program();
        int          kind;
        int          fwd;
        int          v;
        funct3_t     f3;
        logic [11:0] imm;
        logic [4:0]  shamt;
        logic        alt;
        word_t       r;
        for (int k = 0; k < DMEM_WORDS; k++) begin
            dram[k]       = lcg_next();
            model_dram[k] = dram[k];
        end
        // unused words hold an illegal opcode tagged with their index
        for (int k = 0; k < IMEM_WORDS; k++) begin
            irom[k] = {22'(k), 10'h07f};
        end
        irom[0] = i_format(12'(DATA_BASE), 5'd0, 3'b000, 5'd1, `OP_IMM);
        irom[1] = i_format(12'(JALR_BASE), 5'd0, 3'b000, 5'd2, `OP_IMM);
        for (int i = 2; i < PROG_LEN - 1; i++) begin
            kind  = random_below(16);
            fwd   = 2 + random_below(6);
            f3    = funct3_t'(random_below(8));
            alt   = random_below(2) == 1;
            shamt = 5'(random_below(32));
            r     = lcg_next();
            // targets never pass the final illegal word
            if (i + fwd > PROG_LEN - 1) begin
                fwd = PROG_LEN - 1 - i;
            end
            if (kind < 4) begin
                irom[i] = r_format((alt && (f3 == 3'b000 || f3 == 3'b101)) ? 7'h20 : 7'h00,
                                   src_reg(), src_reg(), f3, dest_reg());
            end else if (kind < 7) begin
                if (f3 == 3'b001) begin
                    imm = {7'b0, shamt};
                end else if (f3 == 3'b101) begin
                    imm = {1'b0, alt, 5'b0, shamt};
                end else begin
                    imm = r[11:0];
                end
                irom[i] = i_format(imm, src_reg(), f3, dest_reg(), `OP_IMM);
            end else if (kind == 7) begin
                irom[i] = {r[31:12], dest_reg(), `OP_LUI};
            end else if (kind < 10) begin
                v  = random_below(5);
                f3 = funct3_t'(v < 3 ? v : v + 1);
                irom[i] = i_format(aligned_offset(f3), 5'd1, f3, dest_reg(), `OP_LOAD);
            end else if (kind < 12) begin
                f3 = funct3_t'(random_below(3));
                irom[i] = s_format(aligned_offset(f3), src_reg(), 5'd1, f3);
            end else if (kind < 14) begin
                v  = random_below(6);
                f3 = funct3_t'(v < 2 ? v : v + 2);
                irom[i] = b_format(13'(fwd * 4), src_reg(), src_reg(), f3);
            end else if (kind == 14) begin
                irom[i] = j_format(21'(fwd * 4), dest_reg());
            end else begin
                imm     = 12'((i + fwd) * 4 - JALR_BASE);
                irom[i] = i_format(imm, 5'd2, 3'b000, dest_reg(), `OP_JALR);
            end
        end
        irom[PROG_LEN-1] = 32'h0000_0000;
    endtask

    function automatic word_t reference_alu(input funct3_t f3, input logic alt,
                                            input word_t a, input word_t b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  return (a < b) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101:  return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_taken(input funct3_t f3, input word_t a, input word_t b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            default: return a >= b;
        endcase
    endfunction

    // instruction-set model, fills the expected store list
    task automatic run_model();
        word_t       regs [0:31];
        inst_t       w;
        logic [11:0] pc;
        logic [11:0] next_pc;
        word_t       a;
        word_t       b;
        word_t       res;
        word_t       ea;
        word_t       lane;
        word_t       data;
        word_t       imm_i;
        word_t       imm_s;
        word_t       imm_b;
        word_t       imm_j;
        dmem_addr_t  addr;
        byte_en_t    be;
        funct3_t     f3;
        logic        wr;
        logic        running;
        for (int k = 0; k < 32; k++) begin
            regs[k] = '0;
        end
        pc         = '0;
        model_inst = 0;
        model_mem  = 0;
        running    = 1'b1;
        while (running) begin
            w       = irom[pc[11:2]];
            f3      = w[14:12];
            a       = regs[w[19:15]];
            b       = regs[w[24:20]];
            imm_i   = {{20{w[31]}}, w[31:20]};
            imm_s   = {{20{w[31]}}, w[31:25], w[11:7]};
            imm_b   = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            imm_j   = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            next_pc = pc + 12'd4;
            res     = {20'b0, pc} + 32'd4;
            wr      = 1'b0;
            case (w[6:0])
                `OP_LUI: begin
                    res = {w[31:12], 12'b0};
                    wr  = 1'b1;
                end
                `OP_OP: begin
                    res = reference_alu(f3, w[30], a, b);
                    wr  = 1'b1;
                end
                `OP_IMM: begin
                    res = reference_alu(f3, f3 == 3'b101 && w[30], a, imm_i);
                    wr  = 1'b1;
                end
                `OP_LOAD: begin
                    ea   = a + imm_i;
                    addr = ea[11:0];
                    lane = model_dram[addr[11:2]] >> (8 * addr[1:0]);
                    case (f3)
                        3'b000:  res = {{24{lane[7]}}, lane[7:0]};
                        3'b001:  res = {{16{lane[15]}}, lane[15:0]};
                        3'b100:  res = {24'b0, lane[7:0]};
                        3'b101:  res = {16'b0, lane[15:0]};
                        default: res = lane;
                    endcase
                    wr = 1'b1;
                    model_mem++;
                end
                `OP_STORE: begin
                    ea   = a + imm_s;
                    addr = ea[11:0];
                    case (f3[1:0])
                        2'b00:   be = 4'b0001 << addr[1:0];
                        2'b01:   be = 4'b0011 << addr[1:0];
                        default: be = 4'b1111;
                    endcase
                    data = (b << (8 * addr[1:0])) & byte_lanes(be);
                    model_dram[addr[11:2]] = (model_dram[addr[11:2]] & ~byte_lanes(be)) | data;
                    exp_addr_q.push_back(addr);
                    exp_be_q.push_back(be);
                    exp_data_q.push_back(data);
                    model_mem++;
                end
                `OP_BRANCH: begin
                    if (branch_taken(f3, a, b)) begin
                        next_pc = pc + imm_b[11:0];
                    end
                end
                `OP_JAL: begin
                    next_pc = pc + imm_j[11:0];
                    wr      = 1'b1;
                end
                `OP_JALR: begin
                    ea      = a + imm_i;
                    next_pc = {ea[11:2], 2'b00};
                    wr      = 1'b1;
                end
                default: begin
                    running = 1'b0;
                end
            endcase
            if (running) begin
                if (wr && w[11:7] != 5'd0) begin
                    regs[w[11:7]] = res;
                end
                pc = next_pc;
                model_inst++;
            end
        end
        model_final_pc = {20'b0, pc};
    endtask

    // both rams answer one cycle after the address, outputs sampled when stable
    always @(negedge clk) begin
        imem_data <= irom[imem_addr[`IMEM_ADDR_W-1:2]];
        if (dmem_re) begin
            dmem_rdata <= dram[dmem_addr[`DMEM_ADDR_W-1:2]];
        end
        if (dmem_be != '0) begin
            if (halted) begin
                $display("a store to address %h happened after the core halted", dmem_addr);
                report_failure();
            end else if (store_count >= exp_addr_q.size()) begin
                $display("the core made more stores than the model expects");
                report_failure();
            end else begin
                check_addr("dmem_addr", dmem_addr, exp_addr_q[store_count]);
                check_be("dmem_be", dmem_be, exp_be_q[store_count]);
                check_word("dmem_wdata", dmem_wdata & byte_lanes(dmem_be),
                           exp_data_q[store_count]);
                dram[dmem_addr[`DMEM_ADDR_W-1:2]] =
                    (dram[dmem_addr[`DMEM_ADDR_W-1:2]] & ~byte_lanes(dmem_be))
                    | (dmem_wdata & byte_lanes(dmem_be));
                store_count++;
            end
        end
    end

    task automatic check_idle();
        check_bit("halted", halted, 1'b0);
        check_be("dmem_be", dmem_be, '0);
        check_bit("dmem_re", dmem_re, 1'b0);
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: the core never halted within %0d cycles", WATCHDOG_CYCLES);
        report_failure();
    end

    initial begin
        rstn       = 1'b0;
        imem_data  <= '0;
        dmem_rdata <= '0;
        rand_state = SEED;
        build_program();
        run_model();
        $display("model: %0d instructions, %0d memory accesses, %0d stores",
                 model_inst, model_mem, exp_addr_q.size());
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_idle();
        end
        rstn = 1'b1;
        // first instruction is a setup addi
        repeat (4) begin
            @(negedge clk);
            check_idle();
        end
        while (halted !== 1'b1) begin
            @(negedge clk);
        end
        halt_cycle = cycle;
        // the illegal word reaches HALT four states after its fetch
        exp_halt_cycle = RESET_CYCLES + 5 * model_inst + 2 * model_mem + 4;
        if (halt_cycle != exp_halt_cycle) begin
            $display("Mismatch at %0t: halt cycle got %0d expected %0d",
                     $time, halt_cycle, exp_halt_cycle);
            report_failure();
        end
        check_word("imem_addr", word_t'(imem_addr), model_final_pc);
        repeat (10) @(negedge clk);
        check_bit("halted", halted, 1'b1);
        if (store_count != exp_addr_q.size()) begin
            $display("Mismatch at %0t: store count got %0d expected %0d",
                     $time, store_count, exp_addr_q.size());
            report_failure();
        end else begin
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+logic
logic/cpu_pkg.sv
logic/mem_req_if.sv
logic/reg_file.sv
logic/inst_decode.sv
logic/alu.sv
logic/data_mem_port.sv
logic/cpu_top.sv
bench/tb_cpu.sv
